// ==== logic/rv_pkg.sv ====
package rv_pkg;

  // data path width
  localparam int xlen = 64;

  // register index width, 32 architectural registers
  localparam int reg_addr_w = 5;

  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_0000_0000;

  // sd writes all eight bytes
  localparam logic [7:0] store_mask = 8'hff;

  typedef enum logic [4:0] {
    // integer
    op_add,
    op_sub,
    op_addw,
    op_addi,
    op_addiw,
    op_sltiu,
    op_srai,
    op_lui,
    op_auipc,
    // control flow
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    // memory
    op_ld,
    op_lw,
    op_sd,
    // system
    op_ebreak,
    // anything the decoder does not recognise
    op_illegal
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_sltu,
    alu_sra
  } alu_mode_e;

endpackage

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
  input  logic [31:0]                   instr,
  output rv_pkg::opcode_e               op,
  output logic [rv_pkg::reg_addr_w-1:0] rd,
  output logic [rv_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [5:0]                    shamt,
  output logic [rv_pkg::xlen-1:0]       imm_i,
  output logic [rv_pkg::xlen-1:0]       imm_s,
  output logic [rv_pkg::xlen-1:0]       imm_b,
  output logic [rv_pkg::xlen-1:0]       imm_u,
  output logic [rv_pkg::xlen-1:0]       imm_j
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rd    = instr[11:7];
  assign rs1   = instr[19:15];
  assign rs2   = instr[24:20];
  // rv64 shift amount is six bits wide
  assign shamt = instr[25:20];

  // sign-extended immediate forms
  assign imm_i = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(rv_pkg::xlen-13){instr[31]}}, instr[31], instr[7],
                  instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {{(rv_pkg::xlen-32){instr[31]}}, instr[31:12], 12'h000};
  assign imm_j = {{(rv_pkg::xlen-21){instr[31]}}, instr[31], instr[19:12],
                  instr[20], instr[30:21], 1'b0};

  always_comb begin
    op = rv_pkg::op_illegal;
    case (opcode)
      // op
      7'b0110011: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = rv_pkg::op_add;
        if (funct3 == 3'b000 && funct7 == 7'b0100000) op = rv_pkg::op_sub;
      end
      // op-32
      7'b0111011: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = rv_pkg::op_addw;
      end
      // op-imm
      7'b0010011: begin
        if (funct3 == 3'b000) op = rv_pkg::op_addi;
        if (funct3 == 3'b011) op = rv_pkg::op_sltiu;
        if (funct3 == 3'b101 && instr[31:26] == 6'b010000) op = rv_pkg::op_srai;
      end
      // op-imm-32
      7'b0011011: begin
        if (funct3 == 3'b000) op = rv_pkg::op_addiw;
      end
      7'b0110111: op = rv_pkg::op_lui;
      7'b0010111: op = rv_pkg::op_auipc;
      7'b1101111: op = rv_pkg::op_jal;
      7'b1100111: begin
        if (funct3 == 3'b000) op = rv_pkg::op_jalr;
      end
      7'b1100011: begin
        if (funct3 == 3'b000) op = rv_pkg::op_beq;
        if (funct3 == 3'b001) op = rv_pkg::op_bne;
      end
      7'b0000011: begin
        if (funct3 == 3'b011) op = rv_pkg::op_ld;
        if (funct3 == 3'b010) op = rv_pkg::op_lw;
      end
      7'b0100011: begin
        if (funct3 == 3'b011) op = rv_pkg::op_sd;
      end
      // only the exact ebreak encoding is accepted
      7'b1110011: begin
        if (instr == 32'h0010_0073) op = rv_pkg::op_ebreak;
      end
      default: op = rv_pkg::op_illegal;
    endcase
  end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic                          wb_en,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  output logic [rv_pkg::xlen-1:0]       src1,
  output logic [rv_pkg::xlen-1:0]       src2,
  output logic [rv_pkg::xlen-1:0]       a0
);

  logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

  always_ff @(posedge clk) begin
    if (wb_en && rd != '0) begin
      regs[rd] <= wb_data;
    end
  end

  // x0 is never written, so its reads are forced to zero
  assign src1 = (rs1 == '0) ? '0 : regs[rs1];
  assign src2 = (rs2 == '0) ? '0 : regs[rs2];

  // x10 carries the exit code
  assign a0 = regs[10];

endmodule

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_mode_e       mode,
  input  logic [rv_pkg::xlen-1:0] a,
  input  logic [rv_pkg::xlen-1:0] b,
  output logic [rv_pkg::xlen-1:0] result
);

  always_comb begin
    case (mode)
      rv_pkg::alu_add: begin
        result = a + b;
      end
      rv_pkg::alu_sub: begin
        result = a - b;
      end
      rv_pkg::alu_sltu: begin
        result = (a < b) ? {{(rv_pkg::xlen-1){1'b0}}, 1'b1} : '0;
      end
      // shift by the low six bits only
      rv_pkg::alu_sra: begin
        result = $signed(a) >>> b[5:0];
      end
      default: begin
        result = a + b;
      end
    endcase
  end

endmodule

// ==== logic/rv_exec_unit.sv ====
`timescale 1ns/1ps

module rv_exec_unit (
  input  rv_pkg::opcode_e               op,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [5:0]                    shamt,
  input  logic [rv_pkg::xlen-1:0]       imm_i,
  input  logic [rv_pkg::xlen-1:0]       imm_s,
  input  logic [rv_pkg::xlen-1:0]       imm_b,
  input  logic [rv_pkg::xlen-1:0]       imm_u,
  input  logic [rv_pkg::xlen-1:0]       imm_j,
  input  logic [rv_pkg::xlen-1:0]       pc,
  input  logic [rv_pkg::xlen-1:0]       src1,
  input  logic [rv_pkg::xlen-1:0]       src2,
  input  logic [rv_pkg::xlen-1:0]       alu_result,
  input  logic [rv_pkg::xlen-1:0]       dmem_rdata,
  output rv_pkg::alu_mode_e             alu_mode,
  output logic [rv_pkg::xlen-1:0]       alu_a,
  output logic [rv_pkg::xlen-1:0]       alu_b,
  output logic                          wb_en,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic [rv_pkg::xlen-1:0]       next_pc,
  output logic [rv_pkg::xlen-1:0]       dmem_addr,
  output logic [rv_pkg::xlen-1:0]       dmem_wdata,
  output logic [7:0]                    dmem_wmask,
  output logic                          store_req,
  output logic                          halt_req,
  output logic                          illegal
);

  logic [rv_pkg::xlen-1:0] snpc;
  logic [rv_pkg::xlen-1:0] branch_target;
  logic [31:0]             load_word;
  logic                    writes_rd;

  assign snpc          = pc + 64'd4;
  assign branch_target = pc + imm_b;

  // operand and mode selection
  always_comb begin
    alu_mode = rv_pkg::alu_add;
    alu_a    = src1;
    alu_b    = src2;
    case (op)
      rv_pkg::op_sub, rv_pkg::op_beq, rv_pkg::op_bne: begin
        alu_mode = rv_pkg::alu_sub;
      end
      rv_pkg::op_addi, rv_pkg::op_addiw, rv_pkg::op_ld, rv_pkg::op_lw,
      rv_pkg::op_jalr: begin
        alu_b = imm_i;
      end
      rv_pkg::op_sltiu: begin
        alu_mode = rv_pkg::alu_sltu;
        alu_b    = imm_i;
      end
      rv_pkg::op_srai: begin
        alu_mode = rv_pkg::alu_sra;
        alu_b    = {{(rv_pkg::xlen-6){1'b0}}, shamt};
      end
      rv_pkg::op_sd: begin
        alu_b = imm_s;
      end
      rv_pkg::op_auipc: begin
        alu_a = pc;
        alu_b = imm_u;
      end
      rv_pkg::op_jal: begin
        alu_a = pc;
        alu_b = imm_j;
      end
      default: begin
        alu_mode = rv_pkg::alu_add;
      end
    endcase
  end

  // lw picks a half of the doubleword by address bit 2
  assign load_word = dmem_addr[2] ? dmem_rdata[63:32] : dmem_rdata[31:0];

  // write-back data and next pc
  always_comb begin
    writes_rd = 1'b1;
    wb_data   = alu_result;
    next_pc   = snpc;
    case (op)
      rv_pkg::op_addw, rv_pkg::op_addiw: begin
        wb_data = {{(rv_pkg::xlen-32){alu_result[31]}}, alu_result[31:0]};
      end
      rv_pkg::op_lui: begin
        wb_data = imm_u;
      end
      rv_pkg::op_jal: begin
        wb_data = snpc;
        next_pc = alu_result;
      end
      rv_pkg::op_jalr: begin
        wb_data = snpc;
        next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
      end
      rv_pkg::op_lw: begin
        wb_data = {{(rv_pkg::xlen-32){load_word[31]}}, load_word};
      end
      rv_pkg::op_ld: begin
        wb_data = dmem_rdata;
      end
      // branches compare through the subtractor
      rv_pkg::op_beq: begin
        writes_rd = 1'b0;
        next_pc   = (alu_result == '0) ? branch_target : snpc;
      end
      rv_pkg::op_bne: begin
        writes_rd = 1'b0;
        next_pc   = (alu_result != '0) ? branch_target : snpc;
      end
      rv_pkg::op_sd, rv_pkg::op_ebreak, rv_pkg::op_illegal: begin
        writes_rd = 1'b0;
      end
      default: begin
        writes_rd = 1'b1;
      end
    endcase
  end

  assign wb_en = writes_rd && (rd != '0);

  // memory port, address always from the adder
  assign dmem_addr  = alu_result;
  assign dmem_wdata = src2;
  assign store_req  = (op == rv_pkg::op_sd);
  assign dmem_wmask = store_req ? rv_pkg::store_mask : 8'h00;

  assign illegal  = (op == rv_pkg::op_illegal);
  assign halt_req = (op == rv_pkg::op_ebreak) || illegal;

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  logic [31:0]             imem_data,
  output logic [rv_pkg::xlen-1:0] dmem_addr,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic [rv_pkg::xlen-1:0] dmem_wdata,
  output logic [7:0]              dmem_wmask,
  output logic                    dmem_wen,
  output logic                    halted,
  output logic                    trap,
  output logic [rv_pkg::xlen-1:0] exit_code
);

  logic [rv_pkg::xlen-1:0]       pc;
  rv_pkg::opcode_e               op;
  rv_pkg::alu_mode_e             alu_mode;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [5:0]                    shamt;
  logic [rv_pkg::xlen-1:0]       imm_i;
  logic [rv_pkg::xlen-1:0]       imm_s;
  logic [rv_pkg::xlen-1:0]       imm_b;
  logic [rv_pkg::xlen-1:0]       imm_u;
  logic [rv_pkg::xlen-1:0]       imm_j;
  logic [rv_pkg::xlen-1:0]       src1;
  logic [rv_pkg::xlen-1:0]       src2;
  logic [rv_pkg::xlen-1:0]       alu_a;
  logic [rv_pkg::xlen-1:0]       alu_b;
  logic [rv_pkg::xlen-1:0]       alu_result;
  logic [rv_pkg::xlen-1:0]       wb_data;
  logic [rv_pkg::xlen-1:0]       next_pc;
  logic                          wb_en;
  logic                          store_req;
  logic                          halt_req;
  logic                          illegal;
  logic                          active;

  // no architectural update in reset or after a halt
  assign active    = rst_n && !halted;
  assign dmem_wen  = store_req && active;
  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= rv_pkg::reset_pc;
      halted <= 1'b0;
      trap   <= 1'b0;
    end else if (!halted) begin
      // pc stays on the halting instruction
      if (halt_req) begin
        halted <= 1'b1;
        trap   <= illegal;
      end else begin
        pc <= next_pc;
      end
    end
  end

  rv_decoder rv_decoder_inst (
    .instr (imem_data),
    .op    (op),
    .rd    (rd),
    .rs1   (rs1),
    .rs2   (rs2),
    .shamt (shamt),
    .imm_i (imm_i),
    .imm_s (imm_s),
    .imm_b (imm_b),
    .imm_u (imm_u),
    .imm_j (imm_j)
  );

  rv_regfile rv_regfile_inst (
    .clk     (clk),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .wb_en   (wb_en && active),
    .wb_data (wb_data),
    .src1    (src1),
    .src2    (src2),
    .a0      (exit_code)
  );

  rv_alu rv_alu_inst (
    .mode   (alu_mode),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_exec_unit rv_exec_unit_inst (
    .op         (op),
    .rd         (rd),
    .shamt      (shamt),
    .imm_i      (imm_i),
    .imm_s      (imm_s),
    .imm_b      (imm_b),
    .imm_u      (imm_u),
    .imm_j      (imm_j),
    .pc         (pc),
    .src1       (src1),
    .src2       (src2),
    .alu_result (alu_result),
    .dmem_rdata (dmem_rdata),
    .alu_mode   (alu_mode),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .wb_en      (wb_en),
    .wb_data    (wb_data),
    .next_pc    (next_pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .store_req  (store_req),
    .halt_req   (halt_req),
    .illegal    (illegal)
  );

endmodule

// ==== sim/rv_ref_model.svh ====
// program and data memory geometry
localparam int prog_len   = 40;
localparam int dmem_words = 64;
localparam int max_cycles = 200;
localparam logic [63:0] data_base = 64'h0000_0000_0000_1000;

// generated program, one record per instruction slot
rv_pkg::opcode_e p_op [prog_len];
logic [4:0]      p_rd [prog_len];
logic [4:0]      p_rs1 [prog_len];
logic [4:0]      p_rs2 [prog_len];
logic [63:0]     p_imm [prog_len];
int              p_count;

// slots that some earlier jump lands on
logic            p_target [prog_len];

// x1 holds the data base, so it is never a destination
logic [4:0] src_pool [9] = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd10};
logic [4:0] dst_pool [8] = '{5'd0, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd10};

logic [31:0] rng_state = 32'hb6a4_d813;

// model state
logic [63:0] m_regs [32];
logic [63:0] m_mem [dmem_words];
logic [63:0] m_pc;
logic        m_halted;
logic        m_trap;
logic        m_st_en;
logic [63:0] m_st_addr;
logic [63:0] m_st_data;
logic [7:0]  m_st_mask;

function automatic logic [31:0] next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic int rand_below(input int n);
  return int'(next_rand() % 32'(n));
endfunction

function automatic logic [63:0] rand_imm12();
  logic [31:0] r;
  r = next_rand();
  return {{52{r[11]}}, r[11:0]};
endfunction

function automatic logic [63:0] rand_imm_u();
  logic [31:0] r;
  r = next_rand();
  return {{32{r[31]}}, r[31:12], 12'h000};
endfunction

function automatic logic [4:0] pick_src();
  return src_pool[rand_below(9)];
endfunction

function automatic logic [4:0] pick_dst();
  return dst_pool[rand_below(8)];
endfunction

// instruction word from the ISA encodings
function automatic logic [31:0] encode(input rv_pkg::opcode_e op, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [63:0] imm);
  case (op)
    rv_pkg::op_add:    return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
    rv_pkg::op_sub:    return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
    rv_pkg::op_addw:   return {7'h00, rs2, rs1, 3'b000, rd, 7'b0111011};
    rv_pkg::op_addi:   return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    rv_pkg::op_addiw:  return {imm[11:0], rs1, 3'b000, rd, 7'b0011011};
    rv_pkg::op_sltiu:  return {imm[11:0], rs1, 3'b011, rd, 7'b0010011};
    rv_pkg::op_srai:   return {6'b010000, imm[5:0], rs1, 3'b101, rd, 7'b0010011};
    rv_pkg::op_lui:    return {imm[31:12], rd, 7'b0110111};
    rv_pkg::op_auipc:  return {imm[31:12], rd, 7'b0010111};
    rv_pkg::op_jal:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    rv_pkg::op_jalr:   return {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
    rv_pkg::op_beq:    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                               7'b1100011};
    rv_pkg::op_bne:    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11],
                               7'b1100011};
    rv_pkg::op_ld:     return {imm[11:0], rs1, 3'b011, rd, 7'b0000011};
    rv_pkg::op_lw:     return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    rv_pkg::op_sd:     return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    rv_pkg::op_ebreak: return 32'h0010_0073;
    default:           return 32'h0000_0000;
  endcase
endfunction

task automatic emit(input rv_pkg::opcode_e op, input logic [4:0] rd, input logic [4:0] rs1,
                    input logic [4:0] rs2, input logic [63:0] imm);
  p_op[p_count]  = op;
  p_rd[p_count]  = rd;
  p_rs1[p_count] = rs1;
  p_rs2[p_count] = rs2;
  p_imm[p_count] = imm;
  p_count++;
endtask

// x1 points into the middle of the data region, every pool register gets a value
task automatic start_program();
  for (int i = 0; i < prog_len; i++) begin
    p_op[i]     = rv_pkg::op_illegal;
    p_rd[i]     = 5'd0;
    p_rs1[i]    = 5'd0;
    p_rs2[i]    = 5'd0;
    p_imm[i]    = '0;
    p_target[i] = 1'b0;
  end
  p_count = 0;
  emit(rv_pkg::op_lui, 5'd1, 5'd0, 5'd0, data_base);
  emit(rv_pkg::op_addi, 5'd1, 5'd1, 5'd0, 64'h100);
  for (int i = 1; i < 8; i++) begin
    emit(rv_pkg::op_addi, dst_pool[i], 5'd0, 5'd0, rand_imm12());
  end
endtask

task automatic emit_int(input int sel);
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  rd  = pick_dst();
  rs1 = pick_src();
  rs2 = pick_src();
  case (sel)
    0: emit(rv_pkg::op_add, rd, rs1, rs2, '0);
    1: emit(rv_pkg::op_sub, rd, rs1, rs2, '0);
    2: emit(rv_pkg::op_addw, rd, rs1, rs2, '0);
    3: emit(rv_pkg::op_addi, rd, rs1, 5'd0, rand_imm12());
    4: emit(rv_pkg::op_addiw, rd, rs1, 5'd0, rand_imm12());
    5: emit(rv_pkg::op_sltiu, rd, rs1, 5'd0, rand_imm12());
    6: emit(rv_pkg::op_srai, rd, rs1, 5'd0, 64'(rand_below(64)));
    7: emit(rv_pkg::op_lui, rd, 5'd0, 5'd0, rand_imm_u());
    default: emit(rv_pkg::op_auipc, rd, 5'd0, 5'd0, rand_imm_u());
  endcase
endtask

// kind 0 integer only, 1 adds memory, 2 adds control flow
task automatic gen_step(input int kind, input int body_end);
  int          sel;
  int          k;
  logic [4:0]  rs1;
  logic [4:0]  rx;
  logic [63:0] off;
  sel = (kind == 0) ? rand_below(9) : rand_below(14);
  k   = 1 + rand_below(3);
  if (sel < 9) begin
    emit_int(sel);
  end else if (kind == 1) begin
    if (sel < 11) begin
      off = 64'(rand_below(64)) * 64'd8 - 64'd256;
      emit(rv_pkg::op_sd, 5'd0, 5'd1, pick_src(), off);
    end else if (sel < 13) begin
      off = 64'(rand_below(128)) * 64'd4 - 64'd256;
      emit(rv_pkg::op_lw, pick_dst(), 5'd1, 5'd0, off);
    end else begin
      off = 64'(rand_below(64)) * 64'd8 - 64'd256;
      emit(rv_pkg::op_ld, pick_dst(), 5'd1, 5'd0, off);
    end
  end else if (sel < 11) begin
    // equal operands half the time so beq is taken too
    rs1 = pick_src();
    rx  = (rand_below(2) == 0) ? rs1 : pick_src();
    p_target[p_count + k] = 1'b1;
    if (sel == 9) emit(rv_pkg::op_beq, 5'd0, rs1, rx, 64'(4 * k));
    else emit(rv_pkg::op_bne, 5'd0, rs1, rx, 64'(4 * k));
  end else if (sel == 11 || p_count + 3 > body_end || p_target[p_count + 1] ||
               p_target[p_count + 2]) begin
    // a jump into the middle of an auipc/addi/jalr group would lose its target
    p_target[p_count + k] = 1'b1;
    emit(rv_pkg::op_jal, pick_dst(), 5'd0, 5'd0, 64'(4 * k));
  end else begin
    // odd target, jalr clears bit 0
    rx = dst_pool[1 + rand_below(7)];
    p_target[p_count + 2 + k] = 1'b1;
    emit(rv_pkg::op_auipc, rx, 5'd0, 5'd0, '0);
    emit(rv_pkg::op_addi, rx, rx, 5'd0, 64'(4 * (k + 2) + 1));
    emit(rv_pkg::op_jalr, pick_dst(), rx, 5'd0, '0);
  end
endtask

task automatic gen_program(input int kind, input logic end_illegal);
  start_program();
  while (p_count < prog_len - 7) begin
    gen_step(kind, prog_len - 7);
  end
  // fold the working registers into a0
  for (int i = 2; i < 8; i++) begin
    emit(rv_pkg::op_add, 5'd10, 5'd10, 5'(i), '0);
  end
  if (end_illegal) emit(rv_pkg::op_illegal, 5'd0, 5'd0, 5'd0, '0);
  else emit(rv_pkg::op_ebreak, 5'd0, 5'd0, 5'd0, '0);
endtask

task automatic gen_x0_program();
  start_program();
  emit(rv_pkg::op_addi, 5'd0, 5'd0, 5'd0, 64'd77);
  emit(rv_pkg::op_lui, 5'd0, 5'd0, 5'd0, rand_imm_u());
  emit(rv_pkg::op_add, 5'd0, 5'd2, 5'd3, '0);
  emit(rv_pkg::op_add, 5'd10, 5'd0, 5'd0, '0);
  emit(rv_pkg::op_ebreak, 5'd0, 5'd0, 5'd0, '0);
endtask

function automatic logic [63:0] rf(input logic [4:0] r);
  return (r == 5'd0) ? 64'h0 : m_regs[r];
endfunction

function automatic logic [63:0] sext32(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

task automatic model_reset();
  for (int i = 0; i < 32; i++) begin
    m_regs[i] = '0;
  end
  m_pc     = rv_pkg::reset_pc;
  m_halted = 1'b0;
  m_trap   = 1'b0;
  m_st_en  = 1'b0;
endtask

// one instruction at m_pc, leaves the expected store in m_st_*
task automatic model_step();
  int              idx;
  rv_pkg::opcode_e op;
  logic [63:0]     a;
  logic [63:0]     b;
  logic [63:0]     imm;
  logic [63:0]     res;
  logic [63:0]     nxt;
  logic [63:0]     addr;
  logic [63:0]     dw;
  logic            wr;
  idx = 0;
  op  = rv_pkg::op_illegal;
  if (m_pc < 64'(4 * prog_len)) begin
    idx = int'(m_pc[7:2]);
    op  = p_op[idx];
  end
  a       = rf(p_rs1[idx]);
  b       = rf(p_rs2[idx]);
  imm     = p_imm[idx];
  addr    = a + imm;
  dw      = m_mem[addr[8:3]];
  res     = '0;
  nxt     = m_pc + 64'd4;
  wr      = 1'b1;
  m_st_en = 1'b0;
  case (op)
    rv_pkg::op_add:   res = a + b;
    rv_pkg::op_sub:   res = a - b;
    rv_pkg::op_addw:  res = sext32(a[31:0] + b[31:0]);
    rv_pkg::op_addi:  res = a + imm;
    rv_pkg::op_addiw: res = sext32(a[31:0] + imm[31:0]);
    rv_pkg::op_sltiu: res = {63'd0, a < imm};
    rv_pkg::op_srai:  res = $signed(a) >>> imm[5:0];
    rv_pkg::op_lui:   res = imm;
    rv_pkg::op_auipc: res = m_pc + imm;
    rv_pkg::op_ld:    res = dw;
    rv_pkg::op_lw:    res = addr[2] ? sext32(dw[63:32]) : sext32(dw[31:0]);
    rv_pkg::op_jal: begin
      res = m_pc + 64'd4;
      nxt = m_pc + imm;
    end
    rv_pkg::op_jalr: begin
      res = m_pc + 64'd4;
      nxt = {addr[63:1], 1'b0};
    end
    rv_pkg::op_beq: begin
      wr = 1'b0;
      if (a == b) nxt = m_pc + imm;
    end
    rv_pkg::op_bne: begin
      wr = 1'b0;
      if (a != b) nxt = m_pc + imm;
    end
    rv_pkg::op_sd: begin
      wr        = 1'b0;
      m_st_en   = 1'b1;
      m_st_addr = addr;
      m_st_data = b;
      m_st_mask = rv_pkg::store_mask;
      m_mem[addr[8:3]] = b;
    end
    default: begin
      wr       = 1'b0;
      nxt      = m_pc;
      m_halted = 1'b1;
      m_trap   = (op == rv_pkg::op_illegal);
    end
  endcase
  if (wr && p_rd[idx] != 5'd0) m_regs[p_rd[idx]] = res;
  m_pc = nxt;
endtask

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  `include "rv_ref_model.svh"

  logic                    clk = 1'b0;
  logic                    rst_n = 1'b0;
  logic [rv_pkg::xlen-1:0] imem_addr;
  logic [31:0]             imem_data;
  logic [rv_pkg::xlen-1:0] dmem_addr;
  logic [rv_pkg::xlen-1:0] dmem_rdata;
  logic [rv_pkg::xlen-1:0] dmem_wdata;
  logic [7:0]              dmem_wmask;
  logic                    dmem_wen;
  logic                    halted;
  logic                    trap;
  logic [rv_pkg::xlen-1:0] exit_code;

  logic [31:0]             imem [prog_len];
  logic [rv_pkg::xlen-1:0] dmem [dmem_words];
  int                      test_errors;
  int                      tests_run;
  int                      tests_failed;

  always #5 clk = ~clk;

  // combinational memories, words past the program read as zero
  assign imem_data  = (imem_addr < 64'(4 * prog_len)) ? imem[imem_addr[7:2]] : 32'h0;
  assign dmem_rdata = (dmem_addr[63:9] == data_base[63:9]) ? dmem[dmem_addr[8:3]] : 64'h0;

  always @(posedge clk) begin
    if (dmem_wen && dmem_addr[63:9] == data_base[63:9]) begin
      for (int lane = 0; lane < 8; lane++) begin
        if (dmem_wmask[lane]) dmem[dmem_addr[8:3]][8*lane +: 8] <= dmem_wdata[8*lane +: 8];
      end
    end
  end

  rv_core rv_core_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_wen   (dmem_wen),
    .halted     (halted),
    .trap       (trap),
    .exit_code  (exit_code)
  );

  task automatic check_pc(input string name, input logic [rv_pkg::xlen-1:0] expected,
                          input logic [rv_pkg::xlen-1:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_exit(input logic [rv_pkg::xlen-1:0] expected,
                            input logic [rv_pkg::xlen-1:0] actual);
    if (actual !== expected) begin
      $display("Error: exit_code expected 0x%h got 0x%h", expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%h got 0x%h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_store(input logic exp_en, input logic [rv_pkg::xlen-1:0] exp_addr,
                             input logic [rv_pkg::xlen-1:0] exp_data, input logic [7:0] exp_mask);
    check_flag("dmem_wen", exp_en, dmem_wen);
    if (exp_en) begin
      check_pc("dmem_addr", exp_addr, dmem_addr);
      check_pc("dmem_wdata", exp_data, dmem_wdata);
      if (dmem_wmask !== exp_mask) begin
        $display("Error: dmem_wmask expected 0x%h got 0x%h", exp_mask, dmem_wmask);
        test_errors++;
      end
    end
  endtask

  task automatic load_memories();
    logic [63:0] word;
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = encode(p_op[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
    end
    for (int i = 0; i < dmem_words; i++) begin
      word[63:32] = next_rand();
      word[31:0]  = next_rand();
      dmem[i]    <= word;
      m_mem[i]    = word;
    end
  endtask

  // kind 3 is the x0 program
  task automatic run_test(input string name, input int kind, input logic end_illegal);
    int n;
    int hold_idx;
    test_errors = 0;
    @(posedge clk);
    #1 rst_n = 1'b0;
    if (kind == 3) gen_x0_program();
    else gen_program(kind, end_illegal);
    load_memories();
    // a store word sits at the reset pc while reset is held
    imem[0] = encode(rv_pkg::op_sd, 5'd0, 5'd1, 5'd10, '0);
    model_reset();
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_pc("imem_addr", rv_pkg::reset_pc, imem_addr);
    check_flag("halted", 1'b0, halted);
    check_flag("trap", 1'b0, trap);
    check_flag("dmem_wen", 1'b0, dmem_wen);
    @(posedge clk);
    #1 rst_n = 1'b1;
    imem[0] = encode(p_op[0], p_rd[0], p_rs1[0], p_rs2[0], p_imm[0]);
    n = 0;
    @(negedge clk);
    while (!halted && !m_halted && n < max_cycles) begin
      check_pc("imem_addr", m_pc, imem_addr);
      model_step();
      check_store(m_st_en, m_st_addr, m_st_data, m_st_mask);
      n++;
      @(negedge clk);
    end
    if (n >= max_cycles) begin
      $display("core did not halt within %0d cycles", max_cycles);
      test_errors++;
    end else begin
      check_flag("halted", m_halted, halted);
      check_flag("trap", m_trap, trap);
      check_exit(m_regs[10], exit_code);
      // halted core must hold pc and stay off the bus
      // whatever word then shows up at pc, stores and register writes alternate
      hold_idx = int'(m_pc[7:2]);
      for (int i = 0; i < 5; i++) begin
        @(posedge clk);
        #1;
        if (i % 2 == 0) imem[hold_idx] = encode(rv_pkg::op_sd, 5'd0, 5'd1, 5'd10, '0);
        else imem[hold_idx] = encode(rv_pkg::op_addi, 5'd10, 5'd10, 5'd0, 64'd1);
        @(negedge clk);
        check_pc("imem_addr", m_pc, imem_addr);
        check_flag("halted", 1'b1, halted);
        check_flag("dmem_wen", 1'b0, dmem_wen);
        check_exit(m_regs[10], exit_code);
      end
    end
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s failed with %0d errors", tests_run, name, test_errors);
    end
  endtask

  initial begin
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = 32'h0;
    end
    for (int i = 0; i < dmem_words; i++) begin
      dmem[i] <= '0;
    end
    repeat (20) run_test("integer", 0, 1'b0);
    repeat (10) run_test("memory", 1, 1'b0);
    repeat (10) run_test("control", 2, 1'b0);
    run_test("x0 writes", 3, 1'b0);
    run_test("illegal end", 0, 1'b1);
    run_test("illegal end", 2, 1'b1);
    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+sim
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_exec_unit.sv
logic/rv_core.sv
sim/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module tb_rv_core \
  --Mdir obj_dir -o tb_rv_core_sim

# the simulator exit status is not trusted, the log decides
./obj_dir/tb_rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported failure, see sim.log"
  exit 1
fi
